/* design/aesPkg.sv */
/* AES-128 shared definitions
   Block width, core pipeline depth and the GF(2^8) byte functions */

package aesPkg;

   // ------------------------------
   // Sizes
   // ------------------------------

   // AES block and key width
   localparam int blockWidth = 128;
   // Initial key-addition register plus ten round stages
   localparam int coreLatency = 11;

   // ------------------------------
   // GF(2^8) arithmetic
   // ------------------------------

   // Multiply by x, reduced by the AES polynomial
   function automatic logic [7:0] xtime(input logic [7:0] value);
      return {value[6:0], 1'b0} ^ (value[7] ? 8'h1b : 8'h00);
   endfunction

   // Shift-and-add field multiply
   function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
      logic [7:0] product;
      logic [7:0] addend;
      product = 8'h00;
      addend = a;
      for (int i = 0; i < 8; i++) begin
         if (b[i]) begin
            product = product ^ addend;
         end
         addend = xtime(addend);
      end
      return product;
   endfunction

   // S-box as inverse plus affine map, no lookup table
   function automatic logic [7:0] sbox(input logic [7:0] value);
      logic [7:0] power;
      logic [7:0] inverse;
      power = value;
      inverse = 8'h01;
      // x^254 is the inverse, and maps zero to zero
      for (int i = 1; i < 8; i++) begin
         power = gfMul(power, power);
         inverse = gfMul(inverse, power);
      end
      // Affine step as rotations of the inverse
      return inverse
         ^ {inverse[6:0], inverse[7]}
         ^ {inverse[5:0], inverse[7:6]}
         ^ {inverse[4:0], inverse[7:5]}
         ^ {inverse[3:0], inverse[7:4]}
         ^ 8'h63;
   endfunction

   // ------------------------------
   // Key schedule constants
   // ------------------------------

   // Round constant for rounds 1 to 10
   function automatic logic [7:0] rcon(input int roundIndex);
      case (roundIndex)
         1: return 8'h01;
         2: return 8'h02;
         3: return 8'h04;
         4: return 8'h08;
         5: return 8'h10;
         6: return 8'h20;
         7: return 8'h40;
         8: return 8'h80;
         9: return 8'h1b;
         10: return 8'h36;
         default: return 8'h00;
      endcase
   endfunction

endpackage

/* design/aesRound.sv */
/* AES-128 round stage
   Expands the next round key on the fly and registers state and key */

`timescale 1ns/1ps

module aesRound #(
   parameter int roundIndex = 1
) (
   input  logic                          Clock,
   input  logic [aesPkg::blockWidth-1:0] stateIn,
   input  logic [aesPkg::blockWidth-1:0] keyIn,
   output logic [aesPkg::blockWidth-1:0] stateOut,
   output logic [aesPkg::blockWidth-1:0] keyOut
);

   // Byte n of the state sits at bits [127-8n -: 8], column-major
   logic [31:0]                   tempWord;
   logic [aesPkg::blockWidth-1:0] nextKey;
   logic [aesPkg::blockWidth-1:0] subState;
   logic [aesPkg::blockWidth-1:0] shiftState;
   logic [aesPkg::blockWidth-1:0] mixState;

   // ------------------------------
   // Key expansion
   // ------------------------------

   always_comb begin : keyExpand
      // RotWord then SubWord on the last key word
      tempWord = {aesPkg::sbox(keyIn[23:16]),
                  aesPkg::sbox(keyIn[15:8]),
                  aesPkg::sbox(keyIn[7:0]),
                  aesPkg::sbox(keyIn[31:24])};
      tempWord = tempWord ^ {aesPkg::rcon(roundIndex), 24'h000000};
      // Chain XOR across the four words
      nextKey[127:96] = keyIn[127:96] ^ tempWord;
      nextKey[95:64]  = keyIn[95:64] ^ nextKey[127:96];
      nextKey[63:32]  = keyIn[63:32] ^ nextKey[95:64];
      nextKey[31:0]   = keyIn[31:0] ^ nextKey[63:32];
   end

   // ------------------------------
   // SubBytes and ShiftRows
   // ------------------------------

   always_comb begin : subShift
      for (int n = 0; n < 16; n++) begin
         subState[127-8*n -: 8] = aesPkg::sbox(stateIn[127-8*n -: 8]);
      end
      // Row r rotates left by r columns
      for (int c = 0; c < 4; c++) begin
         for (int r = 0; r < 4; r++) begin
            shiftState[127-8*(r+4*c) -: 8] = subState[127-8*(r+4*((c+r)%4)) -: 8];
         end
      end
   end

   // ------------------------------
   // MixColumns
   // ------------------------------

   always_comb begin : mixCols
      logic [7:0] a0, a1, a2, a3;
      mixState = shiftState;
      // Last round has no MixColumns
      if (roundIndex != 10) begin
         for (int c = 0; c < 4; c++) begin
            a0 = shiftState[127-32*c -: 8];
            a1 = shiftState[119-32*c -: 8];
            a2 = shiftState[111-32*c -: 8];
            a3 = shiftState[103-32*c -: 8];
            // Fixed matrix 2 3 1 1, rotated per row
            mixState[127-32*c -: 8] = aesPkg::xtime(a0 ^ a1) ^ a1 ^ a2 ^ a3;
            mixState[119-32*c -: 8] = aesPkg::xtime(a1 ^ a2) ^ a2 ^ a3 ^ a0;
            mixState[111-32*c -: 8] = aesPkg::xtime(a2 ^ a3) ^ a3 ^ a0 ^ a1;
            mixState[103-32*c -: 8] = aesPkg::xtime(a3 ^ a0) ^ a0 ^ a1 ^ a2;
         end
      end
   end

   // ------------------------------
   // Stage register
   // ------------------------------

   // AddRoundKey with the freshly expanded key
   always_ff @(posedge Clock) begin
      stateOut <= mixState ^ nextKey;
      keyOut   <= nextKey;
   end

endmodule

/* design/aesCore.sv */
/* Pipelined AES-128 encrypt core
   Initial key addition then ten round stages, one block per cycle */

`timescale 1ns/1ps

module aesCore (
   input  logic                          Clock,
   input  logic [aesPkg::blockWidth-1:0] plainText,
   input  logic [aesPkg::blockWidth-1:0] key,
   output logic [aesPkg::blockWidth-1:0] cipherText
);

   // Entry k is the state after stage k
   logic [aesPkg::blockWidth-1:0] stateChain [aesPkg::coreLatency];
   // Entry k is the round key after stage k
   logic [aesPkg::blockWidth-1:0] keyChain [aesPkg::coreLatency-1];

   // ------------------------------
   // Initial AddRoundKey
   // ------------------------------

   // Key travels with its block
   always_ff @(posedge Clock) begin
      stateChain[0] <= plainText ^ key;
      keyChain[0]   <= key;
   end

   // ------------------------------
   // Round stages
   // ------------------------------

   genvar r;
   generate
      for (r = 1; r < aesPkg::coreLatency; r++) begin : roundStage
         if (r < aesPkg::coreLatency - 1) begin : midRound
            aesRound #(
               .roundIndex (r)
            ) aesRound_inst (
               .Clock    (Clock),
               .stateIn  (stateChain[r-1]),
               .keyIn    (keyChain[r-1]),
               .stateOut (stateChain[r]),
               .keyOut   (keyChain[r])
            );
         end else begin : lastRound
            // Final round key feeds no later stage
            aesRound #(
               .roundIndex (r)
            ) aesRound_inst (
               .Clock    (Clock),
               .stateIn  (stateChain[r-1]),
               .keyIn    (keyChain[r-1]),
               .stateOut (stateChain[r]),
               .keyOut   ()
            );
         end
      end
   endgenerate

   // Tenth round output is the ciphertext
   assign cipherText = stateChain[aesPkg::coreLatency-1];

endmodule

/* design/laneSpreader.sv */
/* Lane spreader
   Registers the item and gives each lane its own counter block */

`timescale 1ns/1ps

module laneSpreader #(
   parameter int numLanes = 4
) (
   input  logic                                   Clock,
   input  logic                                   reset,
   input  logic [aesPkg::blockWidth-1:0]          nonce,
   input  logic [aesPkg::blockWidth-1:0]          key,
   input  logic [numLanes*aesPkg::blockWidth-1:0] dataIn,
   input  logic                                   inValid,
   output logic [numLanes*aesPkg::blockWidth-1:0] laneBlock,
   output logic [aesPkg::blockWidth-1:0]          laneKey,
   output logic [numLanes*aesPkg::blockWidth-1:0] laneData,
   output logic                                   laneValid
);

   // ------------------------------
   // Counter blocks
   // ------------------------------

   genvar k;
   generate
      for (k = 0; k < numLanes; k++) begin : lane
         // Lane offset, full width so the add wraps mod 2^128
         localparam logic [aesPkg::blockWidth-1:0] laneIndex = k;
         always_ff @(posedge Clock) begin
            laneBlock[k*aesPkg::blockWidth +: aesPkg::blockWidth] <= nonce + laneIndex;
         end
      end
   endgenerate

   // ------------------------------
   // Key, data and valid
   // ------------------------------

   // Payload, no reset
   always_ff @(posedge Clock) begin
      laneKey  <= key;
      laneData <= dataIn;
   end

   always_ff @(posedge Clock) begin
      if (reset) begin
         laneValid <= 1'b0;
      end else begin
         laneValid <= inValid;
      end
   end

endmodule

/* design/padMasker.sv */
/* Pad masker
   Delays data and valid to meet the keystream, then XORs and registers */

`timescale 1ns/1ps

module padMasker #(
   parameter int numLanes = 4
) (
   input  logic                                   Clock,
   input  logic                                   reset,
   input  logic [numLanes*aesPkg::blockWidth-1:0] laneData,
   input  logic                                   laneValid,
   input  logic [numLanes*aesPkg::blockWidth-1:0] keyStream,
   output logic [numLanes*aesPkg::blockWidth-1:0] dataOut,
   output logic                                   outValid
);

   // Matches the core pipeline depth
   localparam int depth = aesPkg::coreLatency;
   localparam int laneBits = numLanes * aesPkg::blockWidth;

   logic [laneBits-1:0] dataDelay [depth];
   logic [depth-1:0]    validDelay;

   // ------------------------------
   // Data path
   // ------------------------------

   always_ff @(posedge Clock) begin
      dataDelay[0] <= laneData;
      for (int i = 1; i < depth; i++) begin
         dataDelay[i] <= dataDelay[i-1];
      end
      // Same op both ways, encrypt or decrypt
      dataOut <= dataDelay[depth-1] ^ keyStream;
   end

   // ------------------------------
   // Valid path
   // ------------------------------

   // Shift in at bit 0, oldest at the top
   always_ff @(posedge Clock) begin
      if (reset) begin
         validDelay <= '0;
         outValid   <= 1'b0;
      end else begin
         validDelay <= {validDelay[depth-2:0], laneValid};
         outValid   <= validDelay[depth-1];
      end
   end

endmodule

/* design/aesKeystream.sv */
/* AES-128 counter-mode keystream block
   Spreads counters over lanes, encrypts in parallel, masks the data */

`timescale 1ns/1ps

module aesKeystream #(
   parameter int numLanes = 4
) (
   input  logic                                   Clock,
   input  logic                                   reset,
   input  logic [aesPkg::blockWidth-1:0]          nonce,
   input  logic [aesPkg::blockWidth-1:0]          key,
   input  logic [numLanes*aesPkg::blockWidth-1:0] dataIn,
   input  logic                                   inValid,
   output logic [numLanes*aesPkg::blockWidth-1:0] dataOut,
   output logic                                   outValid
);

   logic [numLanes*aesPkg::blockWidth-1:0] laneBlock;
   logic [aesPkg::blockWidth-1:0]          laneKey;
   logic [numLanes*aesPkg::blockWidth-1:0] laneData;
   logic                                   laneValid;
   logic [numLanes*aesPkg::blockWidth-1:0] keyStream;

   // ------------------------------
   // Input stage
   // ------------------------------

   laneSpreader #(
      .numLanes (numLanes)
   ) laneSpreader_inst (
      .Clock     (Clock),
      .reset     (reset),
      .nonce     (nonce),
      .key       (key),
      .dataIn    (dataIn),
      .inValid   (inValid),
      .laneBlock (laneBlock),
      .laneKey   (laneKey),
      .laneData  (laneData),
      .laneValid (laneValid)
   );

   // One core per lane, shared key
   genvar k;
   generate
      for (k = 0; k < numLanes; k++) begin : lane
         aesCore aesCore_inst (
            .Clock      (Clock),
            .plainText  (laneBlock[k*aesPkg::blockWidth +: aesPkg::blockWidth]),
            .key        (laneKey),
            .cipherText (keyStream[k*aesPkg::blockWidth +: aesPkg::blockWidth])
         );
      end
   endgenerate

   // ------------------------------
   // Output stage
   // ------------------------------

   padMasker #(
      .numLanes (numLanes)
   ) padMasker_inst (
      .Clock     (Clock),
      .reset     (reset),
      .laneData  (laneData),
      .laneValid (laneValid),
      .keyStream (keyStream),
      .dataOut   (dataOut),
      .outValid  (outValid)
   );

endmodule

/* test/tbAesModel.svh */
/* AES-128 behavioral model for the testbench
   Byte-level encrypt and the counter-mode output expected per item */

`ifndef TB_AES_MODEL_SVH
`define TB_AES_MODEL_SVH

// S-box, filled once at the start of the run
logic [7:0] sboxTable [256];

// Multiply by x modulo the AES polynomial
function automatic logic [7:0] fieldDouble(input logic [7:0] value);
   logic [7:0] shifted;
   shifted = value << 1;
   if (value[7]) begin
      shifted = shifted ^ 8'h1b;
   end
   return shifted;
endfunction

// Peasant multiply in GF(2^8)
function automatic logic [7:0] fieldMultiply(input logic [7:0] a, input logic [7:0] b);
   logic [7:0] acc;
   logic [7:0] x;
   logic [7:0] y;
   acc = 8'h00;
   x = a;
   y = b;
   while (y != 8'h00) begin
      if (y[0]) begin
         acc = acc ^ x;
      end
      x = fieldDouble(x);
      y = y >> 1;
   end
   return acc;
endfunction

// Inverse by search, then the affine map bit by bit
task automatic fillSboxTable();
   logic [7:0] inv;
   logic [7:0] bits;
   for (int a = 0; a < 256; a++) begin
      inv = 8'h00;
      for (int c = 1; c < 256; c++) begin
         if (fieldMultiply(a[7:0], c[7:0]) == 8'h01) begin
            inv = c[7:0];
         end
      end
      for (int i = 0; i < 8; i++) begin
         bits[i] = inv[i] ^ inv[(i+4)%8] ^ inv[(i+5)%8] ^ inv[(i+6)%8] ^ inv[(i+7)%8];
      end
      sboxTable[a] = bits ^ 8'h63;
   end
endtask

// Byte n of a block sits at bits [127-8n -: 8]
function automatic logic [127:0] aesEncrypt(input logic [127:0] cipherKey,
                                            input logic [127:0] block);
   logic [7:0]   s [16];
   logic [7:0]   t [16];
   logic [7:0]   w [16];
   logic [7:0]   rc;
   logic [127:0] result;
   rc = 8'h01;
   for (int n = 0; n < 16; n++) begin
      w[n] = cipherKey[127-8*n -: 8];
      s[n] = block[127-8*n -: 8] ^ w[n];
   end
   for (int round = 1; round <= 10; round++) begin
      // Next round key, first word gets the rotated and substituted last word
      w[0] = w[0] ^ sboxTable[w[13]] ^ rc;
      w[1] = w[1] ^ sboxTable[w[14]];
      w[2] = w[2] ^ sboxTable[w[15]];
      w[3] = w[3] ^ sboxTable[w[12]];
      for (int i = 4; i < 16; i++) begin
         w[i] = w[i] ^ w[i-4];
      end
      rc = fieldDouble(rc);
      // SubBytes and ShiftRows
      for (int c = 0; c < 4; c++) begin
         for (int r = 0; r < 4; r++) begin
            t[r+4*c] = sboxTable[s[r+4*((c+r)%4)]];
         end
      end
      // MixColumns except in round 10
      for (int c = 0; c < 4; c++) begin
         for (int r = 0; r < 4; r++) begin
            if (round == 10) begin
               s[r+4*c] = t[r+4*c];
            end else begin
               s[r+4*c] = fieldMultiply(8'h02, t[4*c+r])
                  ^ fieldMultiply(8'h03, t[4*c+(r+1)%4])
                  ^ t[4*c+(r+2)%4] ^ t[4*c+(r+3)%4];
            end
         end
      end
      for (int n = 0; n < 16; n++) begin
         s[n] = s[n] ^ w[n];
      end
   end
   for (int n = 0; n < 16; n++) begin
      result[127-8*n -: 8] = s[n];
   end
   return result;
endfunction

// Data XOR the pad, lane k uses counter nonce+k
function automatic logic [busBits-1:0] counterExpect(input logic [127:0] cipherKey,
                                                     input logic [127:0] itemNonce,
                                                     input logic [busBits-1:0] itemData);
   logic [busBits-1:0] pad;
   logic [127:0]       offset;
   for (int k = 0; k < lanes; k++) begin
      offset = 128'(k);
      pad[k*128 +: 128] = aesEncrypt(cipherKey, itemNonce + offset);
   end
   return itemData ^ pad;
endfunction

`endif

/* test/tbAesKeystream.sv */
/* Testbench for the AES-128 counter-mode keystream block
   Directed tests against a behavioral model, 4 lanes */

`timescale 1ns/1ps

module tbAesKeystream;

   localparam int lanes = 4;
   localparam int busBits = lanes * aesPkg::blockWidth;
   // Drive edge to output edge
   localparam int pipeDelay = 13;
   localparam int waitLimit = 50;

   logic               Clock;
   logic               reset;
   logic [127:0]       nonce;
   logic [127:0]       key;
   logic [busBits-1:0] dataIn;
   logic               inValid;
   logic [busBits-1:0] dataOut;
   logic               outValid;

   // Items in flight, in issue order
   logic [busBits-1:0] expectData [$];
   int                 expectCycle [$];
   // Streaming record for the round trip
   logic [127:0]       streamKey [$];
   logic [127:0]       streamNonce [$];
   logic [busBits-1:0] streamData [$];
   logic [busBits-1:0] streamOut [$];
   logic               captureStream = 1'b0;

   int cycleCount = 0;
   int outCount = 0;
   int errorCount = 0;
   int timeoutCount = 0;

   `include "tbAesModel.svh"

   aesKeystream #(
      .numLanes (lanes)
   ) aesKeystream_inst (
      .Clock    (Clock),
      .reset    (reset),
      .nonce    (nonce),
      .key      (key),
      .dataIn   (dataIn),
      .inValid  (inValid),
      .dataOut  (dataOut),
      .outValid (outValid)
   );

   // ------------------------------
   // Clock and cycle count
   // ------------------------------

   initial begin
      Clock = 1'b0;
      forever #4 Clock = ~Clock;
   end

   initial begin
      forever begin
         @(posedge Clock);
         cycleCount++;
      end
   end

   // ------------------------------
   // Helpers
   // ------------------------------

   task automatic compareValue(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
      if (actual !== expected) begin
         errorCount++;
         $display("MISMATCH %s: got %0h, expected %0h", name, actual, expected);
      end
   endtask

   function automatic logic [127:0] randomBlock();
      return {$urandom, $urandom, $urandom, $urandom};
   endfunction

   function automatic logic [busBits-1:0] randomData();
      logic [busBits-1:0] value;
      for (int k = 0; k < lanes; k++) begin
         value[k*128 +: 128] = randomBlock();
      end
      return value;
   endfunction

   // Entered and left 1 ns after a rising edge
   task automatic sendItem(input logic [127:0] itemKey, input logic [127:0] itemNonce,
                           input logic [busBits-1:0] itemData,
                           input logic [busBits-1:0] expected);
      key = itemKey;
      nonce = itemNonce;
      dataIn = itemData;
      inValid = 1'b1;
      expectData.push_back(expected);
      expectCycle.push_back(cycleCount);
      @(posedge Clock);
      #1;
      inValid = 1'b0;
   endtask

   task automatic idleCycles(input int count);
      repeat (count) begin
         @(posedge Clock);
         #1;
      end
   endtask

   // Bounded wait until every item has come out
   task automatic waitDrain(input string testName);
      int waited;
      waited = 0;
      while (expectData.size() != 0 && waited < waitLimit) begin
         @(posedge Clock);
         #1;
         waited++;
      end
      if (expectData.size() != 0) begin
         timeoutCount++;
         $display("Timeout in %s: %0d outputs never appeared within %0d cycles",
                  testName, expectData.size(), waitLimit);
         expectData.delete();
         expectCycle.delete();
      end
   endtask

   // ------------------------------
   // Output monitor
   // ------------------------------

   // Samples on the falling edge, away from the drive point
   initial begin
      logic [busBits-1:0] expected;
      int                 issued;
      forever begin
         @(negedge Clock);
         if (reset === 1'b0 && $isunknown(outValid)) begin
            errorCount++;
            $display("outValid is unknown at cycle %0d", cycleCount);
         end else if (reset === 1'b0 && outValid === 1'b1) begin
            outCount++;
            if (expectData.size() == 0) begin
               errorCount++;
               $display("Unexpected output at cycle %0d with nothing in flight", cycleCount);
            end else begin
               expected = expectData.pop_front();
               issued = expectCycle.pop_front();
               compareValue("latency", 128'(cycleCount - issued), 128'(pipeDelay));
               for (int k = 0; k < lanes; k++) begin
                  compareValue($sformatf("dataOut lane %0d", k), dataOut[k*128 +: 128],
                               expected[k*128 +: 128]);
               end
               if (captureStream) begin
                  streamOut.push_back(dataOut);
               end
            end
         end
      end
   end

   // ------------------------------
   // Directed tests
   // ------------------------------

   task automatic resetQuiet();
      repeat (5) begin
         @(posedge Clock);
         #1;
         compareValue("outValid in reset", 128'(outValid), 128'(0));
      end
      reset = 1'b0;
      repeat (20) begin
         @(posedge Clock);
         #1;
         compareValue("outValid idle", 128'(outValid), 128'(0));
      end
   endtask

   // FIPS-197 C.1 vector on lane 0
   task automatic knownAnswer();
      logic [127:0]       fipsKey;
      logic [127:0]       fipsNonce;
      logic [busBits-1:0] expected;
      fipsKey = 128'h000102030405060708090a0b0c0d0e0f;
      fipsNonce = 128'h00112233445566778899aabbccddeeff;
      expected = counterExpect(fipsKey, fipsNonce, '0);
      compareValue("model lane 0", expected[127:0], 128'h69c4e0d86a7b0430d8cdb78070b4c55a);
      expected[127:0] = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
      sendItem(fipsKey, fipsNonce, '0, expected);
      waitDrain("knownAnswer");
   endtask

   // Nonces near all ones make the lane counters wrap
   task automatic laneKeystream();
      logic [127:0] itemKey;
      logic [127:0] itemNonce;
      for (int i = 0; i < 8; i++) begin
         itemKey = randomBlock();
         itemNonce = randomBlock();
         if (i == 3) begin
            itemNonce = '1;
         end else if (i == 5) begin
            itemNonce = '1 - 128'd1;
         end
         sendItem(itemKey, itemNonce, '0, counterExpect(itemKey, itemNonce, '0));
         waitDrain("laneKeystream");
      end
   endtask

   // Back to back, many items in flight
   task automatic streaming();
      logic [127:0]       itemKey;
      logic [127:0]       itemNonce;
      logic [busBits-1:0] itemData;
      captureStream = 1'b1;
      for (int i = 0; i < 40; i++) begin
         itemKey = randomBlock();
         itemNonce = randomBlock();
         itemData = randomData();
         streamKey.push_back(itemKey);
         streamNonce.push_back(itemNonce);
         streamData.push_back(itemData);
         sendItem(itemKey, itemNonce, itemData, counterExpect(itemKey, itemNonce, itemData));
      end
      waitDrain("streaming");
      captureStream = 1'b0;
      compareValue("streaming output count", 128'(streamOut.size()), 128'(40));
   endtask

   task automatic gapsAndCount();
      logic [127:0]       itemKey;
      logic [127:0]       itemNonce;
      logic [busBits-1:0] itemData;
      int                 countBefore;
      countBefore = outCount;
      for (int i = 0; i < 30; i++) begin
         itemKey = randomBlock();
         itemNonce = randomBlock();
         itemData = randomData();
         sendItem(itemKey, itemNonce, itemData, counterExpect(itemKey, itemNonce, itemData));
         idleCycles($urandom_range(3, 0));
      end
      waitDrain("gapsAndCount");
      compareValue("outValid count", 128'(outCount - countBefore), 128'(30));
   endtask

   // Same key and nonce undo the mask
   task automatic roundTrip();
      for (int i = 0; i < streamOut.size(); i++) begin
         sendItem(streamKey[i], streamNonce[i], streamOut[i], streamData[i]);
      end
      waitDrain("roundTrip");
   endtask

   // ------------------------------
   // Sequence and report
   // ------------------------------

   initial begin
      void'($urandom(32'h701a));
      reset = 1'b1;
      inValid = 1'b0;
      nonce = '0;
      key = '0;
      dataIn = '0;
      fillSboxTable();
      resetQuiet();
      knownAnswer();
      laneKeystream();
      streaming();
      gapsAndCount();
      roundTrip();
      idleCycles(5);
      $display("Errors: %0d mismatches, %0d timeouts", errorCount, timeoutCount);
      if (errorCount == 0 && timeoutCount == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

/* tb.f */
+incdir+test
design/aesPkg.sv
design/aesRound.sv
design/aesCore.sv
design/laneSpreader.sv
design/padMasker.sv
design/aesKeystream.sv
test/tbAesKeystream.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and decide from the log

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f tb.f --top-module tbAesKeystream \
   -o simAesKeystream \
   && ./obj_dir/simAesKeystream > sim.log 2>&1 \
   ; cat sim.log 2>/dev/null \
   ; grep -q "Simulation finished: PASS" sim.log \
   && echo "run.sh: simulation passed" \
   || { echo "run.sh: simulation failed"; exit 1; }
